// ==== sim.f ====
+incdir+testbench
src/alu_geom_pkg.sv
src/alu_types_pkg.sv
src/operand_skew.sv
src/chunk_stage.sv
src/result_deskew.sv
src/chunked_alu.sv
testbench/tb_chunked_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the chunked ALU testbench with Verilator, run it, then search the log

verilator --binary --timing -f sim.f --top-module tb_chunked_alu -Mdir obj_dir \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_chunked_alu > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== testbench/alu_model.svh ====
/*
 * reference model and random source for the chunked ALU testbench
 * full-word operators, no chunking
 */

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// one step of a 32-bit linear congruential generator
// low bits cycle quickly, callers should take the upper half
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected result for one operand set
function automatic alu_result_t alu_model(input operands_t o);
    alu_result_t r;

    // arithmetic wraps at the word width
    r.sum  = o.a + o.b;
    r.diff = o.a - o.b;

    // reductions look at a only
    r.flags.red_and = &o.a;
    r.flags.red_or  = |o.a;
    r.flags.red_xor = ^o.a;

    // compare of a against the third operand
    r.flags.cmp_eq  = (o.a == o.c);
    r.flags.cmp_neq = (o.a != o.c);
    return r;
endfunction

`endif

// ==== testbench/tb_chunked_alu.sv ====
/*
 * testbench for the chunked ALU
 * random and corner operand sets, scoreboard against a full-word model
 */

module tb_chunked_alu
    import alu_geom_pkg::*;
    import alu_types_pkg::*;
();

    `include "alu_model.svh"

    ////////////////////////////////////////////////////////////
    // run lengths and timeout
    ////////////////////////////////////////////////////////////

    localparam int reset_cycles = 10;
    localparam int burst_sets   = 200;
    localparam int gapped_sets  = 150;
    // 10 reduction corners plus 5 compare corners
    localparam int corner_sets  = 15;
    // gapped stream inserts at most one idle cycle per set
    localparam int stim_cycles  = alu_latency + 1 + burst_sets + corner_sets
                                + 2 * gapped_sets;
    // each test ends with one idle cycle and a wait for the pipe to empty
    localparam int drain_cycles   = 6 * (alu_latency + 2);
    localparam int timeout_cycles = reset_cycles + stim_cycles + drain_cycles
                                  + alu_latency + 20;

    logic        clk;
    logic        rst;
    logic        op_valid;
    operands_t   ops;
    logic        res_valid;
    alu_result_t res;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;

    // scoreboard of expected results and the cycle each one is due in
    alu_result_t exp_q [$];
    int          due_q [$];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    chunked_alu chunked_alu_inst (
        .clk       (clk),
        .rst       (rst),
        .op_valid  (op_valid),
        .ops       (ops),
        .res_valid (res_valid),
        .res       (res)
    );

    // cycle counter doubles as the run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d results still pending",
                     cycle_count, exp_q.size());
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input flags_t exp, input flags_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Mismatch at time %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Mismatch at time %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // outputs are sampled mid-cycle, well clear of the rising edge
    always @(negedge clk) begin : monitor
        logic        exp_valid;
        alu_result_t exp_res;

        exp_valid = (due_q.size() > 0) && (due_q[0] == cycle_count);
        check_valid("res_valid", exp_valid, res_valid);
        // a missing pulse still retires its entry so later sets stay aligned
        if (exp_valid) begin
            exp_res = exp_q.pop_front();
            void'(due_q.pop_front());
            if (res_valid) begin
                check_word("res.sum", exp_res.sum, res.sum);
                check_word("res.diff", exp_res.diff, res.diff);
                check_flags("res.flags", exp_res.flags, res.flags);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    // word made of the upper halves of two generator steps
    task automatic next_word(output word_t w);
        logic [31:0] first;

        rng_state = lcg_next(rng_state);
        first     = rng_state;
        rng_state = lcg_next(rng_state);
        w = {first[31:16], rng_state[31:16]};
    endtask

    task automatic random_ops(output operands_t o);
        next_word(o.a);
        next_word(o.b);
        next_word(o.c);
    endtask

    // set is taken in at the next rising edge and due alu_latency cycles on
    task automatic send_set(input operands_t o);
        @(posedge clk);
        #1;
        op_valid = 1'b1;
        ops      = o;
        exp_q.push_back(alu_model(o));
        due_q.push_back(cycle_count + alu_latency);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        op_valid = 1'b0;
    endtask

    // wait until every accepted set has come back
    task automatic drain();
        idle_cycle();
        while (exp_q.size() > 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        test_count++;
        if (error_count == start_errors) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            $display("test %0d %s: fail, %0d errors", test_count, name,
                     error_count - start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int          start_errors;
        operands_t   o;
        word_t       r;
        chunk_t      diff_bits;

        rst       = 1'b1;
        op_valid  = 1'b0;
        ops       = '0;
        rng_state = 32'he7c3_ff46;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // monitor flags any pulse while nothing is queued
        start_errors = error_count;
        repeat (alu_latency) idle_cycle();
        report_test("reset quiet", start_errors);

        start_errors = error_count;
        random_ops(o);
        send_set(o);
        drain();
        report_test("fixed latency", start_errors);

        start_errors = error_count;
        repeat (burst_sets) begin
            random_ops(o);
            send_set(o);
        end
        drain();
        report_test("back-to-back throughput", start_errors);

        start_errors = error_count;
        random_ops(o);
        o.a = '1;
        send_set(o);
        random_ops(o);
        o.a = '0;
        send_set(o);
        // a single cleared bit in each chunk in turn, then a single set bit
        for (int k = 0; k < n_chunks; k++) begin
            random_ops(o);
            next_word(r);
            o.a = ~(word_t'(1) << (k * chunk_w + int'(r[2:0])));
            send_set(o);
        end
        for (int k = 0; k < n_chunks; k++) begin
            random_ops(o);
            next_word(r);
            o.a = word_t'(1) << (k * chunk_w + int'(r[2:0]));
            send_set(o);
        end
        drain();
        report_test("reduction corners", start_errors);

        start_errors = error_count;
        random_ops(o);
        o.c = o.a;
        send_set(o);
        // c differs from a in chunk k only
        for (int k = 0; k < n_chunks; k++) begin
            random_ops(o);
            next_word(r);
            diff_bits = (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
            o.c = o.a ^ (word_t'(diff_bits) << (k * chunk_w));
            send_set(o);
        end
        drain();
        report_test("compare corners", start_errors);

        start_errors = error_count;
        repeat (gapped_sets) begin
            next_word(r);
            if (r % 3 == 0) begin
                idle_cycle();
            end
            random_ops(o);
            send_set(o);
        end
        drain();
        report_test("gapped stream", start_errors);

        if (exp_q.size() != 0) begin
            $display("scoreboard not empty at end, %0d results never arrived",
                     exp_q.size());
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0 && exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/chunked_alu.sv ====
/*
 * chunked ALU top level
 * skews operands across the chunk stages, chains the stages and
 * deskews the results, one operand set accepted per cycle
 */

module chunked_alu
    import alu_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        op_valid,
    input  operands_t   ops,
    output logic        res_valid,
    output alu_result_t res
);

    ////////////////////////////////////////////////////////////
    // stage wiring, one lane per chunk of the word
    ////////////////////////////////////////////////////////////

    chunk_ops_t stage_ops [$bits(word_t) / $bits(chunk_t)];
    logic [$bits(word_t) / $bits(chunk_t) - 1:0] stage_valid;
    logic [$bits(word_t) / $bits(chunk_t) - 1:0] stage_out_valid;
    chunk_res_t res_chunks [$bits(word_t) / $bits(chunk_t)];

    // chain[k] feeds stage k, chain[0] is the seed
    chain_t chain [$bits(word_t) / $bits(chunk_t) + 1];

    // identity values for add, sub, and, or, xor and eq
    assign chain[0] = '{
        carry:   1'b0,
        borrow:  1'b0,
        run_and: 1'b1,
        run_or:  1'b0,
        run_xor: 1'b0,
        run_eq:  1'b1
    };

    operand_skew skew_inst (
        .clk         (clk),
        .rst         (rst),
        .op_valid    (op_valid),
        .ops         (ops),
        .stage_ops   (stage_ops),
        .stage_valid (stage_valid)
    );

    for (genvar k = 0; k < $bits(word_t) / $bits(chunk_t); k++) begin : stage_inst
        chunk_stage stage_inst (
            .clk       (clk),
            .rst       (rst),
            .in_valid  (stage_valid[k]),
            .in_ops    (stage_ops[k]),
            .chain_in  (chain[k]),
            .out_valid (stage_out_valid[k]),
            .chain_out (chain[k+1]),
            .res_chunk (res_chunks[k])
        );
    end

    // last stage's chain and valid close out the set
    result_deskew deskew_inst (
        .clk        (clk),
        .rst        (rst),
        .res_chunks (res_chunks),
        .last_chain (chain[$bits(word_t) / $bits(chunk_t)]),
        .last_valid (stage_out_valid[$bits(word_t) / $bits(chunk_t) - 1]),
        .res_valid  (res_valid),
        .res        (res)
    );

endmodule

// ==== src/result_deskew.sv ====
/*
 * result deskew
 * realigns the staggered result chunks of one set and derives the
 * final flags from the last stage's chain
 */

module result_deskew
    import alu_geom_pkg::*;
    import alu_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  chunk_res_t  res_chunks [n_chunks],
    input  chain_t      last_chain,
    input  logic        last_valid,
    output logic        res_valid,
    output alu_result_t res
);

    chunk_res_t aligned [n_chunks];

    // chunk k left its stage n_chunks-1-k cycles before the last one
    for (genvar k = 0; k < n_chunks; k++) begin : g_lane
        if (k == n_chunks - 1) begin : g_direct
            assign aligned[k] = res_chunks[k];
        end else begin : g_delay
            chunk_res_t slot [n_chunks-1-k];

            always_ff @(posedge clk) begin
                slot[0] <= res_chunks[k];
                for (int i = 1; i < n_chunks - 1 - k; i++) begin
                    slot[i] <= slot[i-1];
                end
            end

            assign aligned[k] = slot[n_chunks-2-k];
        end
    end

    // last stage already registered its flags and valid
    assign res_valid = last_valid && !rst;

    always_comb begin
        for (int k = 0; k < n_chunks; k++) begin
            res.sum[k*chunk_w +: chunk_w]  = aligned[k].sum;
            res.diff[k*chunk_w +: chunk_w] = aligned[k].diff;
        end
        // carry and borrow out of the top chunk are dropped
        res.flags.red_and = last_chain.run_and;
        res.flags.red_or  = last_chain.run_or;
        res.flags.red_xor = last_chain.run_xor;
        res.flags.cmp_eq  = last_chain.run_eq;
        res.flags.cmp_neq = ~last_chain.run_eq;
    end

endmodule

// ==== src/chunk_stage.sv ====
/*
 * chunk stage
 * one pipeline stage, adds, subtracts, reduces and compares one chunk
 * and passes carry, borrow and running flags to the next stage
 */

module chunk_stage
    import alu_geom_pkg::*;
    import alu_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  chunk_ops_t in_ops,
    input  chain_t     chain_in,
    output logic       out_valid,
    output chain_t     chain_out,
    output chunk_res_t res_chunk
);

    ////////////////////////////////////////////////////////////
    // arithmetic on this chunk
    ////////////////////////////////////////////////////////////

    // one extra bit on top catches carry out and borrow out
    logic [chunk_w:0] sum_ext;
    logic [chunk_w:0] diff_ext;

    always_comb begin
        sum_ext = {1'b0, in_ops.a} + {1'b0, in_ops.b}
                + {{chunk_w{1'b0}}, chain_in.carry};
        // wraps below zero when a borrow is needed, top bit then reads 1
        diff_ext = {1'b0, in_ops.a} - {1'b0, in_ops.b}
                 - {{chunk_w{1'b0}}, chain_in.borrow};
    end

    ////////////////////////////////////////////////////////////
    // next chain state and result chunk
    ////////////////////////////////////////////////////////////

    chain_t     chain_next;
    chunk_res_t res_next;

    always_comb begin
        chain_next.carry  = sum_ext[chunk_w];
        chain_next.borrow = diff_ext[chunk_w];

        // serial fold of the reductions, one chunk per stage
        chain_next.run_and = chain_in.run_and & (&in_ops.a);
        chain_next.run_or  = chain_in.run_or  | (|in_ops.a);
        chain_next.run_xor = chain_in.run_xor ^ (^in_ops.a);

        // equality holds only while every chunk so far matched
        chain_next.run_eq = chain_in.run_eq & (in_ops.a == in_ops.c);

        res_next.sum  = sum_ext[chunk_w-1:0];
        res_next.diff = diff_ext[chunk_w-1:0];
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            chain_out <= '0;
            res_chunk <= '0;
        end else begin
            out_valid <= in_valid;
            // hold the last set while the lane is idle
            if (in_valid) begin
                chain_out <= chain_next;
                res_chunk <= res_next;
            end
        end
    end

endmodule

// ==== src/operand_skew.sv ====
/*
 * operand skew
 * cuts each operand set into chunks and hands chunk k to stage k,
 * k cycles after the set was taken in
 */

module operand_skew
    import alu_geom_pkg::*;
    import alu_types_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                op_valid,
    input  operands_t           ops,
    output chunk_ops_t          stage_ops [n_chunks],
    output logic [n_chunks-1:0] stage_valid
);

    for (genvar k = 0; k < n_chunks; k++) begin : g_lane
        chunk_ops_t lane_in;

        // slice chunk k out of each operand word
        assign lane_in.a = ops.a[k*chunk_w +: chunk_w];
        assign lane_in.b = ops.b[k*chunk_w +: chunk_w];
        assign lane_in.c = ops.c[k*chunk_w +: chunk_w];

        if (k == 0) begin : g_direct
            // lowest chunk enters stage 0 right away
            assign stage_ops[k]   = lane_in;
            assign stage_valid[k] = op_valid;
        end else begin : g_delay
            chunk_ops_t   slot [k];
            logic [k-1:0] slot_valid;

            // data shift line, k slots deep
            always_ff @(posedge clk) begin
                slot[0] <= lane_in;
                for (int i = 1; i < k; i++) begin
                    slot[i] <= slot[i-1];
                end
            end

            // valid travels alongside the chunk
            always_ff @(posedge clk) begin
                if (rst) begin
                    slot_valid <= '0;
                end else begin
                    slot_valid[0] <= op_valid;
                    for (int i = 1; i < k; i++) begin
                        slot_valid[i] <= slot_valid[i-1];
                    end
                end
            end

            assign stage_ops[k]   = slot[k-1];
            assign stage_valid[k] = slot_valid[k-1];
        end
    end

endmodule

// ==== src/alu_types_pkg.sv ====
/*
 * chunked ALU data types
 * operand sets, per-chunk slices, chain state and results
 */

package alu_types_pkg;

    import alu_geom_pkg::*;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [chunk_w-1:0] chunk_t;

    // one full operand set, a and b feed add/sub, c is the compare operand
    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } operands_t;

    // the same set cut down to one chunk
    typedef struct packed {
        chunk_t a;
        chunk_t b;
        chunk_t c;
    } chunk_ops_t;

    // state carried from stage k to stage k+1
    typedef struct packed {
        logic carry;
        logic borrow;
        logic run_and;
        logic run_or;
        logic run_xor;
        logic run_eq;
    } chain_t;

    // per-stage slice of the arithmetic results
    typedef struct packed {
        chunk_t sum;
        chunk_t diff;
    } chunk_res_t;

    typedef struct packed {
        logic red_and;
        logic red_or;
        logic red_xor;
        logic cmp_eq;
        logic cmp_neq;
    } flags_t;

    // full result word set, 69 bits
    typedef struct packed {
        word_t  sum;
        word_t  diff;
        flags_t flags;
    } alu_result_t;

endpackage

// ==== src/alu_geom_pkg.sv ====
/*
 * chunked ALU geometry
 * word and chunk sizes, stage count and pipeline latency
 */

package alu_geom_pkg;

    ////////////////////////////////////////////////////////////
    // word geometry
    ////////////////////////////////////////////////////////////

    // operand width in bits
    localparam int word_w = 32;

    // bits handled by one pipeline stage
    localparam int chunk_w = 8;

    // one stage per chunk, word_w must be a multiple of chunk_w
    localparam int n_chunks = word_w / chunk_w;

    ////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////

    // each stage adds one register, deskew adds none on the last chunk
    // so input to result is one cycle per chunk
    localparam int alu_latency = n_chunks;

endpackage
